// ==== source/rv_exec_defs.svh ====
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// Datapath and register file size
`define XLEN        32
`define NUM_REGS    32

// Major opcodes, instr[6:0]
`define OP_ARITH    7'b0110011 // R-type
`define OP_ADDI     7'b0010011
`define OP_BRANCH   7'b1100011
`define OP_JALR     7'b1100111

// funct3 codes, instr[14:12]
`define FUNCT3_BEQ  3'b000
`define FUNCT3_BNE  3'b001
`define FUNCT3_BLT  3'b100
`define FUNCT3_BGE  3'b101
`define FUNCT3_SLL  3'b001
`define FUNCT3_SRL  3'b101
`define FUNCT3_AND  3'b111
`define FUNCT3_OR   3'b110
`define FUNCT3_XOR  3'b100

// funct7 code, instr[31:25]
`define FUNCT7_SUB  7'b0100000

`endif

// ==== source/rv_exec_pkg.sv ====
`include "rv_exec_defs.svh"

package rv_exec_pkg;

    // Class handed from the main decoder to the ALU control unit
    typedef enum logic [1:0] {
        ctrl_add    = 2'b00, // ADDI path
        ctrl_branch = 2'b01, // Compare picked by funct3
        ctrl_funct  = 2'b10  // Opcode and funct fields decide
    } alu_ctrl_op_e;

    typedef enum logic [3:0] {
        func_add  = 4'd0,
        func_sub  = 4'd1,
        func_sll  = 4'd2,
        func_srl  = 4'd3,
        func_and  = 4'd4,
        func_or   = 4'd5,
        func_xor  = 4'd6,
        func_beq  = 4'd7,
        func_bne  = 4'd8,
        func_blt  = 4'd9,
        func_bge  = 4'd10,
        func_jalr = 4'd11,
        func_nop  = 4'd12
    } alu_func_e;

    typedef struct packed {
        alu_func_e         func;
        logic [`XLEN-1:0]  op_a;
        logic [`XLEN-1:0]  op_b;      // Immediate for ADDI and JALR
        logic [`XLEN-1:0]  imm;
        logic [`XLEN-1:0]  pc;
        logic [4:0]        rd;
        logic              reg_write; // Already low for x0
        logic              is_branch;
        logic              is_jalr;
    } issue_t;

    typedef struct packed {
        logic [4:0]        rd;
        logic [`XLEN-1:0]  value;
        logic              reg_write;
        logic              branch_taken;
        logic [`XLEN-1:0]  target;
    } exec_result_t;

endpackage

// ==== source/alu_control_unit.sv ====
`include "rv_exec_defs.svh"

module alu_control_unit
    import rv_exec_pkg::*;
(
    input  alu_ctrl_op_e      alu_ctrl_op, // From main decoder
    input  logic [`XLEN-1:0]  instr,
    output alu_func_e         alu_func
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        case (alu_ctrl_op)
            ctrl_add: begin
                alu_func = func_add;
            end
            ctrl_branch: begin
                case (funct3)
                    `FUNCT3_BEQ: alu_func = func_beq;
                    `FUNCT3_BNE: alu_func = func_bne;
                    `FUNCT3_BLT: alu_func = func_blt;
                    `FUNCT3_BGE: alu_func = func_bge;
                    default:     alu_func = func_nop; // Unknown compare
                endcase
            end
            ctrl_funct: begin
                case (opcode)
                    `OP_ARITH: begin
                        if (funct7 == `FUNCT7_SUB) begin
                            alu_func = func_sub;
                        end else begin
                            case (funct3)
                                `FUNCT3_SLL: alu_func = func_sll;
                                `FUNCT3_SRL: alu_func = func_srl;
                                `FUNCT3_AND: alu_func = func_and;
                                `FUNCT3_OR:  alu_func = func_or;
                                `FUNCT3_XOR: alu_func = func_xor;
                                default:     alu_func = func_add;
                            endcase
                        end
                    end
                    `OP_JALR: alu_func = func_jalr;
                    default:  alu_func = func_nop; // Unsupported opcode
                endcase
            end
            default: begin
                alu_func = func_nop;
            end
        endcase
    end

endmodule

// ==== source/register_file.sv ====
`include "rv_exec_defs.svh"

module register_file #(
    parameter int AW = $clog2(`NUM_REGS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [AW-1:0]     rs1_addr,
    input  logic [AW-1:0]     rs2_addr,
    output logic [`XLEN-1:0]  rs1_data,
    output logic [`XLEN-1:0]  rs2_data,
    input  logic              wr_en,
    input  logic [AW-1:0]     wr_addr,
    input  logic [`XLEN-1:0]  wr_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // x0 is hardwired to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Decode must already have dropped writes to x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_addr != '0);

endmodule

// ==== source/decode_stage.sv ====
`include "rv_exec_defs.svh"

module decode_stage
    import rv_exec_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  logic [`XLEN-1:0]  instr,
    input  logic [`XLEN-1:0]  pc,
    output logic [4:0]        rs1_addr,
    output logic [4:0]        rs2_addr,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic              wb_valid,
    input  logic [4:0]        wb_rd,
    input  logic [`XLEN-1:0]  wb_value,
    output logic              issue_valid,
    output issue_t            issue
);

    logic [6:0]        opcode;
    logic [4:0]        rd;
    alu_ctrl_op_e      alu_ctrl_op;
    alu_func_e         alu_func;
    logic              reg_write;
    logic              is_branch;
    logic              is_jalr;
    logic              use_imm;
    logic [`XLEN-1:0]  imm;
    logic [`XLEN-1:0]  rs1_val;
    logic [`XLEN-1:0]  rs2_val;
    issue_t            next_issue;

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Main decoder
    always_comb begin
        alu_ctrl_op = ctrl_funct; // Unknown opcodes fall out as nop
        reg_write   = 1'b0;
        is_branch   = 1'b0;
        is_jalr     = 1'b0;
        use_imm     = 1'b0;
        case (opcode)
            `OP_ARITH: begin
                reg_write = 1'b1;
            end
            `OP_ADDI: begin
                alu_ctrl_op = ctrl_add;
                reg_write   = 1'b1;
                use_imm     = 1'b1;
            end
            `OP_BRANCH: begin
                alu_ctrl_op = ctrl_branch;
                is_branch   = 1'b1;
            end
            `OP_JALR: begin
                reg_write = 1'b1;
                is_jalr   = 1'b1;
                use_imm   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    alu_control_unit u_alu_ctrl (
        .alu_ctrl_op (alu_ctrl_op),
        .instr       (instr),
        .alu_func    (alu_func)
    );

    // B-immediate for branches, I-immediate otherwise
    assign imm = is_branch ?
        {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0} :
        {{20{instr[31]}}, instr[31:20]};

    // Bypass from the instruction now in execute
    assign rs1_val = (wb_valid && wb_rd == rs1_addr) ? wb_value : rs1_data;
    assign rs2_val = (wb_valid && wb_rd == rs2_addr) ? wb_value : rs2_data;

    always_comb begin
        next_issue.func      = alu_func;
        next_issue.op_a      = rs1_val;
        next_issue.op_b      = use_imm ? imm : rs2_val;
        next_issue.imm       = imm;
        next_issue.pc        = pc;
        next_issue.rd        = rd;
        next_issue.reg_write = reg_write && (rd != 5'd0);
        next_issue.is_branch = is_branch;
        next_issue.is_jalr   = is_jalr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= instr_valid; // Pulse per strobe
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            issue <= next_issue;
        end
    end

    a_func_defined: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> !$isunknown(issue.func) && issue.func <= func_nop);

endmodule

// ==== source/alu.sv ====
`include "rv_exec_defs.svh"

module alu
    import rv_exec_pkg::*;
(
    input  alu_func_e         func,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    output logic [`XLEN-1:0]  result,
    output logic              cond    // Comparison outcome
);

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] sum;
    logic [SHW-1:0]   shamt;

    assign sum   = a + b;
    assign shamt = b[SHW-1:0];

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (func)
            func_add:  result = sum;
            func_sub:  result = a - b;
            func_sll:  result = a << shamt;
            func_srl:  result = a >> shamt; // Logical shift
            func_and:  result = a & b;
            func_or:   result = a | b;
            func_xor:  result = a ^ b;
            func_beq:  cond   = (a == b);
            func_bne:  cond   = (a != b);
            func_blt:  cond   = ($signed(a) < $signed(b));
            func_bge:  cond   = ($signed(a) >= $signed(b));
            func_jalr: result = {sum[`XLEN-1:1], 1'b0}; // Target, LSB cleared
            default: begin
            end
        endcase
    end

endmodule

// ==== source/execute_stage.sv ====
`include "rv_exec_defs.svh"

module execute_stage
    import rv_exec_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  issue_t            issue,
    output logic              wb_valid,
    output logic [4:0]        wb_rd,
    output logic [`XLEN-1:0]  wb_value,
    output logic              res_valid,
    output exec_result_t      res
);

    logic [`XLEN-1:0]  alu_result;
    logic              alu_cond;
    logic [`XLEN-1:0]  pc_plus4;
    logic [`XLEN-1:0]  target;
    logic              taken;
    exec_result_t      next_res;

    alu u_alu (
        .func   (issue.func),
        .a      (issue.op_a),
        .b      (issue.op_b),
        .result (alu_result),
        .cond   (alu_cond)
    );

    assign pc_plus4 = issue.pc + `XLEN'd4;

    // Write-back group, also feeds the decode bypass
    assign wb_valid = issue_valid && issue.reg_write;
    assign wb_rd    = issue.rd;
    assign wb_value = issue.is_jalr ? pc_plus4 : alu_result; // Link address for JALR

    // JALR always jumps
    assign taken  = issue.is_jalr || (issue.is_branch && alu_cond);
    assign target = issue.is_jalr   ? alu_result :
                    issue.is_branch ? issue.pc + issue.imm : '0;

    always_comb begin
        next_res.rd           = issue.rd;
        next_res.value        = wb_value;
        next_res.reg_write    = issue.reg_write;
        next_res.branch_taken = taken;
        next_res.target       = target;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res <= next_res;
        end
    end

    // A branch in the issue slot never writes back
    a_branch_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && issue.is_branch |-> !issue.reg_write);

endmodule

// ==== source/rv_exec_top.sv ====
`include "rv_exec_defs.svh"

module rv_exec_top
    import rv_exec_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid, // One-cycle strobe
    input  logic [`XLEN-1:0]  instr,
    input  logic [`XLEN-1:0]  pc,
    output logic              res_valid,
    output exec_result_t      res
);

    logic [4:0]        rs1_addr;
    logic [4:0]        rs2_addr;
    logic [`XLEN-1:0]  rs1_data;
    logic [`XLEN-1:0]  rs2_data;
    logic              wb_valid;
    logic [4:0]        wb_rd;
    logic [`XLEN-1:0]  wb_value;
    logic              issue_valid;
    issue_t            issue;

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    register_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_value)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .res_valid   (res_valid),
        .res         (res)
    );

endmodule

// ==== bench/clock_gen.sv ====
module clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // Released away from the active edge
    end

endmodule

// ==== bench/rv_exec_tb.sv ====
`include "rv_exec_defs.svh"

module rv_exec_tb
    import rv_exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR    = 400;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * NUM_INSTR + 50;

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    logic [`XLEN-1:0]  instr;
    logic [`XLEN-1:0]  pc;
    logic              res_valid;
    exec_result_t      res;

    logic [31:0]       lfsr;
    logic [`XLEN-1:0]  model_regs [`NUM_REGS];
    exec_result_t      want_q [$];
    int                due_q [$];   // Cycle in which each result must show up
    int                cycle;
    int                tick;
    logic [`XLEN-1:0]  next_pc;

    clock_gen u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_exec_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .res_valid   (res_valid),
        .res         (res)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Mostly x0..x7 so that dependencies are frequent
    function automatic logic [4:0] pick_reg();
        if (take_bits(2) == 0) begin
            return 5'(take_bits(5));
        end
        return 5'(take_bits(3));
    endfunction

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
            fail_run();
        end
    endtask

    task automatic sample_outputs();
        exec_result_t want;
        int           due;
        if (res_valid) begin
            if (want_q.size() == 0) begin
                $display("res_valid went high at %0t ns with no instruction outstanding",
                         $time);
                fail_run();
            end else begin
                want = want_q.pop_front();
                due  = due_q.pop_front();
                check_value("result cycle", cycle, due);
                check_value("rd", res.rd, want.rd);
                check_value("value", res.value, want.value);
                check_value("reg_write", res.reg_write, want.reg_write);
                check_value("branch_taken", res.branch_taken, want.branch_taken);
                check_value("target", res.target, want.target);
            end
        end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
            $display("No result appeared at %0t ns for an instruction due in cycle %0d",
                     $time, due_q[0]);
            fail_run();
        end
    endtask

    // Outputs are stable here; inputs change right after
    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        sample_outputs();
    endtask

    task automatic issue_instr(input logic [`XLEN-1:0] word, input exec_result_t want);
        instr_valid = 1'b1;
        instr       = word;
        pc          = next_pc;
        want_q.push_back(want);
        due_q.push_back(cycle + 2); // Two edges after the strobe
        next_pc     = next_pc + 4;
    endtask

    task automatic build_random(input logic [`XLEN-1:0] at_pc,
                                output logic [`XLEN-1:0] word, output exec_result_t want);
        logic [2:0]        kind;
        logic [2:0]        sel;
        logic [2:0]        f3;
        logic [6:0]        f7;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [11:0]       imm12;
        logic [12:0]       bimm;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        logic [`XLEN-1:0]  ival;
        kind  = 3'(take_bits(3));
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        imm12 = 12'(take_bits(12));
        a     = model_regs[rs1];
        b     = model_regs[rs2];
        ival  = {{20{imm12[11]}}, imm12};
        want  = '0;
        want.rd = rd;
        case (kind)
            3'd0, 3'd1, 3'd2: begin
                sel = 3'(take_bits(3));
                f7  = 7'b0;
                case (sel)
                    3'd1: begin
                        f7         = `FUNCT7_SUB;
                        f3         = 3'b000;
                        want.value = a - b;
                    end
                    3'd2: begin
                        f3         = `FUNCT3_SLL;
                        want.value = a << b[4:0];
                    end
                    3'd3: begin
                        f3         = `FUNCT3_SRL;
                        want.value = a >> b[4:0];
                    end
                    3'd4: begin
                        f3         = `FUNCT3_AND;
                        want.value = a & b;
                    end
                    3'd5: begin
                        f3         = `FUNCT3_OR;
                        want.value = a | b;
                    end
                    3'd6: begin
                        f3         = `FUNCT3_XOR;
                        want.value = a ^ b;
                    end
                    default: begin
                        f3         = 3'b000;
                        want.value = a + b;
                    end
                endcase
                word = {f7, rs2, rs1, f3, rd, `OP_ARITH};
                want.reg_write = (rd != 5'd0);
            end
            3'd3: begin
                word = {imm12, rs1, 3'b000, rd, `OP_ADDI};
                want.value     = a + ival;
                want.reg_write = (rd != 5'd0);
            end
            3'd4, 3'd5: begin
                bimm = {imm12, 1'b0};
                sel  = 3'(take_bits(2));
                case (sel)
                    3'd0: begin
                        f3                = `FUNCT3_BEQ;
                        want.branch_taken = (a == b);
                    end
                    3'd1: begin
                        f3                = `FUNCT3_BNE;
                        want.branch_taken = (a != b);
                    end
                    3'd2: begin
                        f3                = `FUNCT3_BLT;
                        want.branch_taken = ($signed(a) < $signed(b));
                    end
                    default: begin
                        f3                = `FUNCT3_BGE;
                        want.branch_taken = ($signed(a) >= $signed(b));
                    end
                endcase
                word = {bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11], `OP_BRANCH};
                want.rd     = {bimm[4:1], bimm[11]}; // rd field carries immediate bits
                want.target = at_pc + {{19{bimm[12]}}, bimm};
            end
            3'd6: begin
                word = {imm12, rs1, 3'b000, rd, `OP_JALR};
                want.value        = at_pc + 4; // Link address
                want.reg_write    = (rd != 5'd0);
                want.branch_taken = 1'b1;
                want.target       = (a + ival) & ~32'd1;
            end
            default: begin
                word    = {25'(take_bits(25)), 7'b0110111}; // Unsupported opcode
                want.rd = word[11:7];
            end
        endcase
    endtask

    initial begin
        tick = 0;
        while (tick < CYCLE_LIMIT) begin
            @(posedge clk);
            tick++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        fail_run();
    end

    initial begin
        exec_result_t      want;
        logic [`XLEN-1:0]  word;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        lfsr        = 32'h3af3;
        cycle       = 0;
        next_pc     = 32'h0000_1000;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        @(posedge rst_n);
        repeat (4) next_cycle(); // res_valid must stay low here

        // ADD x0, xk, xk reads every register through both ports
        for (int k = 0; k < `NUM_REGS; k++) begin
            next_cycle();
            word = {7'b0, 5'(k), 5'(k), 3'b000, 5'd0, `OP_ARITH};
            want = '0;
            issue_instr(word, want);
        end

        for (int n = `NUM_REGS; n < NUM_INSTR; n++) begin
            if (take_bits(1) != 0) begin
                next_cycle();
                instr_valid = 1'b0; // One idle cycle
            end
            next_cycle();
            build_random(next_pc, word, want);
            issue_instr(word, want);
            if (want.reg_write) begin
                model_regs[want.rd] = want.value;
            end
        end

        repeat (3) begin
            next_cycle();
            instr_valid = 1'b0;
        end

        if (want_q.size() != 0) begin
            $display("%0d expected results never appeared", want_q.size());
            fail_run();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+source
source/rv_exec_pkg.sv
source/alu_control_unit.sv
source/register_file.sv
source/decode_stage.sv
source/alu.sv
source/execute_stage.sv
source/rv_exec_top.sv
bench/clock_gen.sv
bench/rv_exec_tb.sv
